// File: Bender.yml
package:
  name: net_shell

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/net_pkg.sv
      - source/net_reset_ctrl.sv
      - source/net_reg_slice.sv
      - source/net_frame_padder.sv
      - source/net_stream_fifo.sv
      - source/net_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/net_tb.sv

// File: compile.f
+incdir+source
source/net_pkg.sv
source/net_reset_ctrl.sv
source/net_reg_slice.sv
source/net_frame_padder.sv
source/net_stream_fifo.sv
source/net_top.sv
dv/net_tb.sv

// File: dv/net_tb.sv
`timescale 1ns/10ps

`include "net_settings.svh"

module net_tb
  import net_pkg::*;
();

  // Frame budget of the run
  localparam int MAX_LEN      = 24;
  localparam int RX_FRAMES    = 20;
  localparam int FILL_BEATS   = 40;
  localparam int PAD_FRAMES   = 12;
  localparam int PASS_FRAMES  = 12;
  localparam int BURST_FRAMES = 12;
  localparam int MIN_BEATS    = `NET_MIN_FRAME_BEATS;
  // Worst case over all tests
  // Fill test may overshoot by one frame
  localparam int TOTAL_BEATS = RX_FRAMES * MAX_LEN + FILL_BEATS + MAX_LEN +
    PAD_FRAMES * MIN_BEATS + (PASS_FRAMES + BURST_FRAMES) * MAX_LEN;
  localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 4 + 2000;
  localparam int unsigned SEED = 32'h41cc_d95d;

  // Sink ready modes
  localparam int READY_LOW    = 0;
  localparam int READY_HIGH   = 1;
  localparam int READY_RANDOM = 2;

  // Packed beat is {last, keep, data}
  localparam int DB = `NET_DATA_BITS;
  localparam int KB = `NET_KEEP_BITS;
  localparam int LB = DB + KB;
  typedef logic [LB:0] beat_t;

  // Main plus skid register in every receive slice stage
  localparam int SLICE_HOLD = 2 * `NET_SLICE_STAGES;

  logic      rclk;
  logic      rst;
  logic      mac_tx_rst;
  logic      mac_rx_valid;
  logic      mac_rx_ready;
  net_data_t mac_rx_data;
  net_keep_t mac_rx_keep;
  logic      mac_rx_last;
  logic      net_rx_valid;
  logic      net_rx_ready;
  net_data_t net_rx_data;
  net_keep_t net_rx_keep;
  logic      net_rx_last;
  logic      net_tx_valid;
  logic      net_tx_ready;
  net_data_t net_tx_data;
  net_keep_t net_tx_keep;
  logic      net_tx_last;
  logic      mac_tx_valid;
  logic      mac_tx_ready;
  net_data_t mac_tx_data;
  net_keep_t mac_tx_keep;
  logic      mac_tx_last;
  logic      core_ready;
  net_fill_t rx_fill;
  logic      rx_prog_full;

  // Frame under construction
  net_data_t   fr_data [MAX_LEN];
  net_keep_t   fr_keep [MAX_LEN];
  beat_t       rx_exp [$];
  beat_t       tx_exp [$];
  beat_t       rx_want;
  beat_t       tx_want;
  string       test_name;
  int          rx_ready_mode;
  int          tx_ready_mode;
  logic        burst_check;
  logic        tx_in_frame;
  int          cycle_cnt;
  int          sent;
  // Beats accepted on mac_rx and beats delivered on net_rx
  int          rx_taken;
  int          rx_given;
  int unsigned rnd_init;

  net_top i_dut (.*);

  always #4 rclk = ~rclk;

  task automatic report_error(input string msg);
    $display("ERROR: %s (test %s)", msg, test_name);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic compare_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED: test %s, %s: expected 0x%0h, actual 0x%0h",
               test_name, what, expected, actual);
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  endtask

  // Expected output beat i of a frame of n input beats after padding
  function automatic beat_t padded_beat(input int i, input int n);
    net_data_t d;
    int k;
    if (n >= MIN_BEATS) begin
      return {i == n - 1, fr_keep[i], fr_data[i]};
    end else if (i < n - 1) begin
      return {1'b0, fr_keep[i], fr_data[i]};
    end else if (i == n - 1) begin
      // Bytes beyond the original keep come out as zero
      for (k = 0; k < KB; k++) begin
        d[8*k +: 8] = fr_keep[i][k] ? fr_data[i][8*k +: 8] : 8'h00;
      end
      return {1'b0, {KB{1'b1}}, d};
    end
    return {i == MIN_BEATS - 1, {KB{1'b1}}, {DB{1'b0}}};
  endfunction

  // Random payload
  // Final keep contiguous from bit 0
  task automatic build_frame(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      fr_data[i] = {$urandom, $urandom};
      fr_keep[i] = {KB{1'b1}};
    end
    fr_keep[n-1] = 8'hff >> ($urandom % 8);
  endtask

  task automatic sync_drive();
    @(posedge rclk);
    #1;
  endtask

  // Idle cycles before a beat
  // pct is the chance of a gap in percent
  task automatic idle_gap(input int pct);
    int g;
    g = 0;
    if (($urandom % 100) < pct) begin
      g = 1 + $urandom % 3;
    end
    repeat (g) sync_drive();
  endtask

  task automatic drive_rx_beat(input beat_t b);
    mac_rx_valid = 1'b1;
    mac_rx_data  = b[DB-1:0];
    mac_rx_keep  = b[DB +: KB];
    mac_rx_last  = b[LB];
    @(negedge rclk);
    while (mac_rx_ready !== 1'b1) @(negedge rclk);
    sync_drive();
    mac_rx_valid = 1'b0;
  endtask

  task automatic drive_tx_beat(input beat_t b);
    net_tx_valid = 1'b1;
    net_tx_data  = b[DB-1:0];
    net_tx_keep  = b[DB +: KB];
    net_tx_last  = b[LB];
    @(negedge rclk);
    while (net_tx_ready !== 1'b1) @(negedge rclk);
    sync_drive();
    net_tx_valid = 1'b0;
  endtask

  // Receive beats are expected back unchanged
  task automatic send_rx_frame(input int n, input int gap_pct);
    int i;
    build_frame(n);
    for (i = 0; i < n; i++) begin
      rx_exp.push_back({i == n - 1, fr_keep[i], fr_data[i]});
    end
    for (i = 0; i < n; i++) begin
      idle_gap(gap_pct);
      drive_rx_beat({i == n - 1, fr_keep[i], fr_data[i]});
    end
  endtask

  task automatic send_tx_frame(input int n, input int gap_pct);
    int i;
    int out_n;
    build_frame(n);
    out_n = (n < MIN_BEATS) ? MIN_BEATS : n;
    for (i = 0; i < out_n; i++) begin
      tx_exp.push_back(padded_beat(i, n));
    end
    for (i = 0; i < n; i++) begin
      idle_gap(gap_pct);
      drive_tx_beat({i == n - 1, fr_keep[i], fr_data[i]});
    end
  endtask

  task automatic wait_drain();
    while (rx_exp.size() != 0 || tx_exp.size() != 0) @(negedge rclk);
    repeat (4) @(negedge rclk);
  endtask

  // Everything quiet while the datapath is held
  task automatic check_held();
    compare_value("core_ready", 0, core_ready);
    compare_value("mac_tx_valid", 0, mac_tx_valid);
    compare_value("net_rx_valid", 0, net_rx_valid);
    compare_value("mac_rx_ready", 0, mac_rx_ready);
    compare_value("net_tx_ready", 0, net_tx_ready);
    compare_value("rx_fill", 0, rx_fill);
    compare_value("rx_prog_full", 0, rx_prog_full);
  endtask

  // Called right after both reset sources were dropped
  task automatic expect_release();
    int k;
    for (k = 0; k < `NET_RST_SYNC_STAGES + 2; k++) begin
      @(posedge rclk);
      @(negedge rclk);
      compare_value("core_ready release", k >= `NET_RST_SYNC_STAGES, core_ready);
    end
  endtask

  // Sinks change ready just after the edge
  always @(posedge rclk) begin
    #1;
    net_rx_ready = (rx_ready_mode == READY_RANDOM) ? (($urandom % 2) != 0) :
                   (rx_ready_mode == READY_HIGH);
    mac_tx_ready = (tx_ready_mode == READY_RANDOM) ? (($urandom % 2) != 0) :
                   (tx_ready_mode == READY_HIGH);
  end

  // Comparator
  // A beat moves on the next edge when valid and ready
  always @(negedge rclk) begin
    if (net_rx_valid === 1'b1 && net_rx_ready === 1'b1) begin
      if (rx_exp.size() == 0) begin
        report_error("beat on net_rx with no beat expected");
      end else begin
        rx_want = rx_exp.pop_front();
        compare_value("net_rx_data", rx_want[DB-1:0], net_rx_data);
        compare_value("net_rx_keep", rx_want[DB +: KB], net_rx_keep);
        compare_value("net_rx_last", rx_want[LB], net_rx_last);
      end
    end
    if (burst_check && tx_in_frame) begin
      compare_value("mac_tx_valid inside frame", 1, mac_tx_valid);
    end
    if (mac_tx_valid === 1'b1 && mac_tx_ready === 1'b1) begin
      if (tx_exp.size() == 0) begin
        report_error("beat on mac_tx with no beat expected");
      end else begin
        tx_want = tx_exp.pop_front();
        compare_value("mac_tx_data", tx_want[DB-1:0], mac_tx_data);
        compare_value("mac_tx_keep", tx_want[DB +: KB], mac_tx_keep);
        compare_value("mac_tx_last", tx_want[LB], mac_tx_last);
      end
      tx_in_frame = !mac_tx_last;
    end
    // Receive FIFO status
    // Beats in flight sit either in the slice or in the FIFO
    if (core_ready === 1'b1) begin
      compare_value("rx_fill within depth", 1, rx_fill <= `NET_RX_FIFO_DEPTH);
      compare_value("rx_fill not above beats in flight", 1,
                    rx_fill <= rx_taken - rx_given);
      compare_value("rx_fill not below beats in flight", 1,
                    rx_fill + SLICE_HOLD >= rx_taken - rx_given);
      compare_value("rx_prog_full", rx_fill >= `NET_RX_PROG_FULL, rx_prog_full);
    end
    if (mac_rx_valid === 1'b1 && mac_rx_ready === 1'b1) begin
      rx_taken = rx_taken + 1;
    end
    if (net_rx_valid === 1'b1 && net_rx_ready === 1'b1) begin
      rx_given = rx_given + 1;
    end
  end

  always @(posedge rclk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("ERROR: timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  end

  initial begin
    rnd_init      = $urandom(SEED);
    rclk          = 1'b0;
    rst           = 1'b1;
    mac_tx_rst    = 1'b1;
    mac_rx_valid  = 1'b0;
    mac_rx_data   = '0;
    mac_rx_keep   = '0;
    mac_rx_last   = 1'b0;
    net_rx_ready  = 1'b0;
    net_tx_valid  = 1'b0;
    net_tx_data   = '0;
    net_tx_keep   = '0;
    net_tx_last   = 1'b0;
    mac_tx_ready  = 1'b0;
    rx_ready_mode = READY_LOW;
    tx_ready_mode = READY_LOW;
    burst_check   = 1'b0;
    tx_in_frame   = 1'b0;
    cycle_cnt     = 0;
    rx_taken      = 0;
    rx_given      = 0;

    // rst for 5 cycles
    // MAC reset held beyond it
    test_name = "reset";
    repeat (2) @(posedge rclk);
    repeat (3) begin
      @(negedge rclk);
      check_held();
    end
    sync_drive();
    rst = 1'b0;
    repeat (6) begin
      @(negedge rclk);
      check_held();
    end
    sync_drive();
    mac_tx_rst = 1'b0;
    expect_release();

    // MAC reset pulse while running
    test_name = "mac_reset_pulse";
    repeat (3) @(posedge rclk);
    #1;
    mac_tx_rst = 1'b1;
    @(posedge rclk);
    @(negedge rclk);
    compare_value("core_ready after pulse", 0, core_ready);
    sync_drive();
    mac_tx_rst = 1'b0;
    expect_release();

    test_name = "rx_passthrough";
    rx_ready_mode = READY_RANDOM;
    tx_ready_mode = READY_HIGH;
    sync_drive();
    repeat (RX_FRAMES) send_rx_frame(1 + $urandom % MAX_LEN, 30);
    wait_drain();

    // Fill up against a stalled sink then drain
    test_name = "rx_fill";
    rx_ready_mode = READY_LOW;
    sync_drive();
    sent = 0;
    fork
      begin
        while (sent < FILL_BEATS) begin
          rx_fill_len_step();
        end
      end
      begin
        while (rx_fill != `NET_RX_FIFO_DEPTH) @(negedge rclk);
        repeat (8) @(negedge rclk);
        rx_ready_mode = READY_RANDOM;
      end
    join
    wait_drain();

    test_name = "tx_padding";
    tx_ready_mode = READY_RANDOM;
    sync_drive();
    repeat (PAD_FRAMES) send_tx_frame(1 + $urandom % (MIN_BEATS - 1), 30);
    wait_drain();

    test_name = "tx_passthrough";
    sync_drive();
    repeat (PASS_FRAMES) begin
      send_tx_frame(MIN_BEATS + $urandom % (MAX_LEN - MIN_BEATS + 1), 30);
    end
    wait_drain();

    // Sink always ready so a frame must leave in one burst
    test_name = "tx_burst";
    tx_ready_mode = READY_HIGH;
    sync_drive();
    burst_check = 1'b1;
    repeat (BURST_FRAMES) send_tx_frame(1 + $urandom % MAX_LEN, 40);
    wait_drain();
    burst_check = 1'b0;

    test_name = "final";
    repeat (10) @(negedge rclk);
    if (rx_exp.size() == 0 && tx_exp.size() == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("ERROR: %0d receive and %0d transmit beats never arrived",
               rx_exp.size(), tx_exp.size());
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  end

  // One back-to-back frame of the fill test
  task automatic rx_fill_len_step();
    int n;
    n = 1 + $urandom % MAX_LEN;
    send_rx_frame(n, 0);
    sent = sent + n;
  endtask

endmodule

// File: source/net_frame_padder.sv
`timescale 1ns/10ps

`include "net_settings.svh"

module net_frame_padder
  import net_pkg::*;
(
  input  logic      rclk,
  input  logic      rst,
  input  logic      in_valid,
  output logic      in_ready,
  input  net_data_t in_data,
  input  net_keep_t in_keep,
  input  logic      in_last,
  output logic      out_valid,
  input  logic      out_ready,
  output net_data_t out_data,
  output net_keep_t out_keep,
  output logic      out_last
);

  localparam int CNT_BITS = $clog2(`NET_MIN_FRAME_BEATS) + 1;
  localparam logic [CNT_BITS-1:0] MIN_BEATS = CNT_BITS'(`NET_MIN_FRAME_BEATS);

  // Beats of the current frame already emitted
  // Saturates once the minimum is reached
  logic [CNT_BITS-1:0] beat_cnt;
  logic [CNT_BITS-1:0] beat_inc;

  logic      pad_q;
  logic      accept_q;
  logic      load;
  logic      take;
  logic      pad_beat;
  logic      pad_done;
  logic      short_last;
  net_data_t masked_data;

  // Output register is free when empty or being drained
  assign load     = !out_valid || out_ready;
  assign in_ready = accept_q && load;
  assign take     = in_valid && in_ready;
  assign pad_beat = pad_q && load;

  assign beat_inc   = beat_cnt + CNT_BITS'(1);
  assign pad_done   = (beat_inc == MIN_BEATS);
  assign short_last = in_last && (beat_inc < MIN_BEATS);

  // Zero the bytes outside keep
  always_comb begin
    for (int b = 0; b < `NET_KEEP_BITS; b++) begin
      masked_data[8*b +: 8] = in_data[8*b +: 8] & {8{in_keep[b]}};
    end
  end

  always_ff @(posedge rclk) begin
    if (rst) begin
      out_valid <= 1'b0;
      pad_q     <= 1'b0;
      accept_q  <= 1'b0;
      beat_cnt  <= '0;
    end else begin
      // Input opens again whenever no padding is pending
      accept_q <= !pad_q;
      if (pad_beat) begin
        out_valid <= 1'b1;
        if (pad_done) begin
          pad_q    <= 1'b0;
          accept_q <= 1'b1;
          beat_cnt <= '0;
        end else begin
          beat_cnt <= beat_inc;
        end
      end else if (take) begin
        out_valid <= 1'b1;
        if (short_last) begin
          // Short frame so switch to padding
          pad_q    <= 1'b1;
          accept_q <= 1'b0;
          beat_cnt <= beat_inc;
        end else if (in_last) begin
          beat_cnt <= '0;
        end else if (beat_cnt < MIN_BEATS) begin
          beat_cnt <= beat_inc;
        end
      end else if (load) begin
        out_valid <= 1'b0;
      end
    end
  end

  // Payload
  always_ff @(posedge rclk) begin
    if (pad_beat) begin
      out_data <= '0;
      out_keep <= '1;
      out_last <= pad_done;
    end else if (take) begin
      if (short_last) begin
        // Last real beat goes out full width with last cleared
        out_data <= masked_data;
        out_keep <= '1;
        out_last <= 1'b0;
      end else begin
        out_data <= in_data;
        out_keep <= in_keep;
        out_last <= in_last;
      end
    end
  end

endmodule

// File: source/net_pkg.sv
`include "net_settings.svh"

package net_pkg;

  // One beat of stream payload
  typedef logic [`NET_DATA_BITS-1:0] net_data_t;

  // Byte enables, contiguous from bit 0
  typedef logic [`NET_KEEP_BITS-1:0] net_keep_t;

  // Fill count
  // One extra bit so a full FIFO reads as DEPTH
  typedef logic [$clog2(`NET_RX_FIFO_DEPTH):0] net_fill_t;

  // Reset sequencer
  // HOLD while any reset source is up
  // SETTLE counts the release delay
  // RUN lets the datapath go
  typedef enum logic [1:0] {
    RST_HOLD,
    RST_SETTLE,
    RST_RUN
  } net_rst_state_e;

endpackage

// File: source/net_reg_slice.sv
`timescale 1ns/10ps

`include "net_settings.svh"

module net_reg_slice
  import net_pkg::*;
#(
  parameter int N_STAGES = 2
) (
  input  logic      rclk,
  input  logic      rst,
  input  logic      in_valid,
  output logic      in_ready,
  input  net_data_t in_data,
  input  net_keep_t in_keep,
  input  logic      in_last,
  output logic      out_valid,
  input  logic      out_ready,
  output net_data_t out_data,
  output net_keep_t out_keep,
  output logic      out_last
);

  // Stream between stages
  // Index 0 is the slice input and N_STAGES the slice output
  logic [N_STAGES:0] st_valid;
  logic [N_STAGES:0] st_ready;
  logic [N_STAGES:0] st_last;
  net_data_t         st_data [N_STAGES+1];
  net_keep_t         st_keep [N_STAGES+1];

  assign st_valid[0] = in_valid;
  assign st_data[0]  = in_data;
  assign st_keep[0]  = in_keep;
  assign st_last[0]  = in_last;
  assign in_ready    = st_ready[0];

  assign out_valid          = st_valid[N_STAGES];
  assign out_data           = st_data[N_STAGES];
  assign out_keep           = st_keep[N_STAGES];
  assign out_last           = st_last[N_STAGES];
  assign st_ready[N_STAGES] = out_ready;

  for (genvar i = 0; i < N_STAGES; i++) begin : g_stage
    logic      main_valid;
    logic      skid_valid;
    logic      ready_q;
    logic      main_en;
    logic      take;
    net_data_t main_data;
    net_data_t skid_data;
    net_keep_t main_keep;
    net_keep_t skid_keep;
    logic      main_last;
    logic      skid_last;

    // Main register may load when empty or being drained
    assign main_en = st_ready[i+1] || !main_valid;
    assign take    = st_valid[i] && ready_q;

    always_ff @(posedge rclk) begin
      if (rst) begin
        main_valid <= 1'b0;
        skid_valid <= 1'b0;
        ready_q    <= 1'b0;
      end else if (main_en) begin
        // Skid beat has priority since it is older
        main_valid <= skid_valid || take;
        skid_valid <= 1'b0;
        ready_q    <= 1'b1;
      end else if (take) begin
        // Downstream stalled so park the beat
        skid_valid <= 1'b1;
        ready_q    <= 1'b0;
      end
    end

    // Payload
    always_ff @(posedge rclk) begin
      if (main_en) begin
        main_data <= skid_valid ? skid_data : st_data[i];
        main_keep <= skid_valid ? skid_keep : st_keep[i];
        main_last <= skid_valid ? skid_last : st_last[i];
      end else if (take) begin
        skid_data <= st_data[i];
        skid_keep <= st_keep[i];
        skid_last <= st_last[i];
      end
    end

    assign st_ready[i]   = ready_q;
    assign st_valid[i+1] = main_valid;
    assign st_data[i+1]  = main_data;
    assign st_keep[i+1]  = main_keep;
    assign st_last[i+1]  = main_last;
  end

endmodule

// File: source/net_reset_ctrl.sv
`timescale 1ns/10ps

`include "net_settings.svh"

module net_reset_ctrl
  import net_pkg::*;
(
  input  logic rclk,
  input  logic rst,
  input  logic mac_tx_rst,
  output logic net_rst,
  output logic core_ready
);

  // Counter wide enough for the settle delay
  localparam int CNT_BITS = $clog2(`NET_RST_SYNC_STAGES) + 1;
  localparam logic [CNT_BITS-1:0] SETTLE_LAST = CNT_BITS'(`NET_RST_SYNC_STAGES - 1);

  net_rst_state_e state;
  logic [CNT_BITS-1:0] settle_cnt;

  always_ff @(posedge rclk) begin
    if (rst) begin
      state      <= RST_HOLD;
      settle_cnt <= '0;
    end else begin
      case (state)
        RST_HOLD: begin
          settle_cnt <= '0;
          // First edge with both sources low starts the delay
          if (!mac_tx_rst) begin
            state <= RST_SETTLE;
          end
        end
        RST_SETTLE: begin
          if (mac_tx_rst) begin
            state <= RST_HOLD;
          end else if (settle_cnt == SETTLE_LAST) begin
            state <= RST_RUN;
          end else begin
            settle_cnt <= settle_cnt + CNT_BITS'(1);
          end
        end
        RST_RUN: begin
          // MAC dropping back into reset flushes the whole datapath
          if (mac_tx_rst) begin
            state <= RST_HOLD;
          end
        end
        default: begin
          state <= RST_HOLD;
        end
      endcase
    end
  end

  // Decoded straight from the state register
  assign net_rst = (state != RST_RUN);

  // Exported status
  assign core_ready = ~net_rst;

endmodule

// File: source/net_settings.svh
`ifndef NET_SETTINGS_SVH
`define NET_SETTINGS_SVH

// Stream beat geometry
`define NET_DATA_BITS 64
`define NET_KEEP_BITS 8
// Ethernet minimum of 64 bytes in 8-byte beats
`define NET_MIN_FRAME_BEATS 8

// FIFO sizing
`define NET_RX_FIFO_DEPTH 32
`define NET_TX_FIFO_DEPTH 32
`define NET_RX_PROG_FULL 24

// Reset release delay and slice depth
`define NET_RST_SYNC_STAGES 2
`define NET_SLICE_STAGES 2

`endif

// File: source/net_stream_fifo.sv
`timescale 1ns/10ps

`include "net_settings.svh"

module net_stream_fifo
  import net_pkg::*;
#(
  parameter int unsigned DEPTH       = 32,
  parameter bit          PACKET_MODE = 1'b0
) (
  input  logic      rclk,
  input  logic      rst,
  input  logic      in_valid,
  output logic      in_ready,
  input  net_data_t in_data,
  input  net_keep_t in_keep,
  input  logic      in_last,
  output logic      out_valid,
  input  logic      out_ready,
  output net_data_t out_data,
  output net_keep_t out_keep,
  output logic      out_last,
  output net_fill_t fill,
  output logic      prog_full
);

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_BITS-1:0] PTR_LAST = PTR_BITS'(DEPTH - 1);

  // Storage
  net_data_t         mem_data [DEPTH];
  net_keep_t         mem_keep [DEPTH];
  logic [DEPTH-1:0]  mem_last;

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  net_fill_t           count;
  net_fill_t           count_next;
  logic                in_ready_q;
  logic                wr;
  logic                rd;
  logic                frames_ok;

  assign in_ready = in_ready_q;
  assign wr       = in_valid && in_ready_q;

  // Head entry is read straight from the array
  assign out_valid = (count != '0) && frames_ok;
  assign rd        = out_valid && out_ready;
  assign out_data  = mem_data[rd_ptr];
  assign out_keep  = mem_keep[rd_ptr];
  assign out_last  = mem_last[rd_ptr];

  assign count_next = count + net_fill_t'(wr) - net_fill_t'(rd);

  always_ff @(posedge rclk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      in_ready_q <= 1'b0;
    end else begin
      if (wr) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + PTR_BITS'(1);
      end
      if (rd) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + PTR_BITS'(1);
      end
      count <= count_next;
      // Registered ready from the next fill level
      in_ready_q <= (count_next < net_fill_t'(DEPTH));
    end
  end

  always_ff @(posedge rclk) begin
    if (wr) begin
      mem_data[wr_ptr] <= in_data;
      mem_keep[wr_ptr] <= in_keep;
      mem_last[wr_ptr] <= in_last;
    end
  end

  if (PACKET_MODE) begin : g_pkt
    // Frames whose last beat is stored
    net_fill_t frames;

    always_ff @(posedge rclk) begin
      if (rst) begin
        frames <= '0;
      end else begin
        frames <= frames + net_fill_t'(wr && in_last) - net_fill_t'(rd && out_last);
      end
    end

    // Oldest frame is complete whenever any frame is
    assign frames_ok = (frames != '0);
  end else begin : g_plain
    assign frames_ok = 1'b1;
  end

  // Status
  assign fill      = count;
  assign prog_full = (count >= net_fill_t'(`NET_RX_PROG_FULL));

endmodule

// File: source/net_top.sv
`timescale 1ns/10ps

`include "net_settings.svh"

module net_top
  import net_pkg::*;
(
  input  logic      rclk,
  input  logic      rst,
  input  logic      mac_tx_rst,
  // MAC receive stream
  input  logic      mac_rx_valid,
  output logic      mac_rx_ready,
  input  net_data_t mac_rx_data,
  input  net_keep_t mac_rx_keep,
  input  logic      mac_rx_last,
  // User receive stream
  output logic      net_rx_valid,
  input  logic      net_rx_ready,
  output net_data_t net_rx_data,
  output net_keep_t net_rx_keep,
  output logic      net_rx_last,
  // User transmit stream
  input  logic      net_tx_valid,
  output logic      net_tx_ready,
  input  net_data_t net_tx_data,
  input  net_keep_t net_tx_keep,
  input  logic      net_tx_last,
  // MAC transmit stream
  output logic      mac_tx_valid,
  input  logic      mac_tx_ready,
  output net_data_t mac_tx_data,
  output net_keep_t mac_tx_keep,
  output logic      mac_tx_last,
  // Status
  output logic      core_ready,
  output net_fill_t rx_fill,
  output logic      rx_prog_full
);

  logic net_rst;

  // Receive slice to receive FIFO
  logic      rxs_valid;
  logic      rxs_ready;
  net_data_t rxs_data;
  net_keep_t rxs_keep;
  logic      rxs_last;

  // Padder to packet FIFO
  logic      pad_valid;
  logic      pad_ready;
  net_data_t pad_data;
  net_keep_t pad_keep;
  logic      pad_last;

  // Packet FIFO to transmit slice
  logic      txf_valid;
  logic      txf_ready;
  net_data_t txf_data;
  net_keep_t txf_keep;
  logic      txf_last;

  net_reset_ctrl u_reset (
    .rclk       (rclk),
    .rst        (rst),
    .mac_tx_rst (mac_tx_rst),
    .net_rst    (net_rst),
    .core_ready (core_ready)
  );

  // Receive path
  net_reg_slice #(
    .N_STAGES (`NET_SLICE_STAGES)
  ) u_rx_slice (
    .rclk      (rclk),
    .rst       (net_rst),
    .in_valid  (mac_rx_valid),
    .in_ready  (mac_rx_ready),
    .in_data   (mac_rx_data),
    .in_keep   (mac_rx_keep),
    .in_last   (mac_rx_last),
    .out_valid (rxs_valid),
    .out_ready (rxs_ready),
    .out_data  (rxs_data),
    .out_keep  (rxs_keep),
    .out_last  (rxs_last)
  );

  net_stream_fifo #(
    .DEPTH       (`NET_RX_FIFO_DEPTH),
    .PACKET_MODE (1'b0)
  ) u_rx_fifo (
    .rclk      (rclk),
    .rst       (net_rst),
    .in_valid  (rxs_valid),
    .in_ready  (rxs_ready),
    .in_data   (rxs_data),
    .in_keep   (rxs_keep),
    .in_last   (rxs_last),
    .out_valid (net_rx_valid),
    .out_ready (net_rx_ready),
    .out_data  (net_rx_data),
    .out_keep  (net_rx_keep),
    .out_last  (net_rx_last),
    .fill      (rx_fill),
    .prog_full (rx_prog_full)
  );

  // Transmit path
  // Pad short frames then hold each frame until complete
  net_frame_padder u_pad (
    .rclk      (rclk),
    .rst       (net_rst),
    .in_valid  (net_tx_valid),
    .in_ready  (net_tx_ready),
    .in_data   (net_tx_data),
    .in_keep   (net_tx_keep),
    .in_last   (net_tx_last),
    .out_valid (pad_valid),
    .out_ready (pad_ready),
    .out_data  (pad_data),
    .out_keep  (pad_keep),
    .out_last  (pad_last)
  );

  net_stream_fifo #(
    .DEPTH       (`NET_TX_FIFO_DEPTH),
    .PACKET_MODE (1'b1)
  ) u_tx_fifo (
    .rclk      (rclk),
    .rst       (net_rst),
    .in_valid  (pad_valid),
    .in_ready  (pad_ready),
    .in_data   (pad_data),
    .in_keep   (pad_keep),
    .in_last   (pad_last),
    .out_valid (txf_valid),
    .out_ready (txf_ready),
    .out_data  (txf_data),
    .out_keep  (txf_keep),
    .out_last  (txf_last),
    .fill      (),
    .prog_full ()
  );

  net_reg_slice #(
    .N_STAGES (`NET_SLICE_STAGES)
  ) u_tx_slice (
    .rclk      (rclk),
    .rst       (net_rst),
    .in_valid  (txf_valid),
    .in_ready  (txf_ready),
    .in_data   (txf_data),
    .in_keep   (txf_keep),
    .in_last   (txf_last),
    .out_valid (mac_tx_valid),
    .out_ready (mac_tx_ready),
    .out_data  (mac_tx_data),
    .out_keep  (mac_tx_keep),
    .out_last  (mac_tx_last)
  );

endmodule
